// ==== Makefile ====
# Verilator build and run of the frame join testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vframe_join_tb: verilog.f hdl/*.sv bench/*.sv
	verilator --binary -Wno-fatal -j 0 --top-module frame_join_tb -f verilog.f

test: obj_dir/Vframe_join_tb
	./obj_dir/Vframe_join_tb | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/frame_join_tb.sv ====
/*
 * Testbench for the frame join subsystem with 4 ports, a 16-bit tag and depth 8.
 * Each table row sets a tag, per-port frame lengths, per-port user flags
 * and the output ready pattern. Frames go in one port after another and
 * the DUT buffers ahead. Inputs change on the falling edge only.
 * Expected output is rebuilt from the join rules.
 */
module frame_join_tb;

    localparam int s_count_c = 4;
    localparam int tag_width_c = 16;
    localparam int fifo_depth_c = 8;
    localparam int dw_c = join_pkg::data_width_c;
    localparam int tag_words_c = (tag_width_c + dw_c - 1) / dw_c;
    localparam int n_tests_c = 6;

    // ports 0 to 3 read left to right in len and user
    typedef struct packed {
        logic [31:0]             tag;
        logic [0:s_count_c-1][4:0] len;
        logic [0:s_count_c-1]    user;
        logic                    rand_ready;
    } test_row_t;

    // tag, frame lengths, user flags, random output ready
    localparam test_row_t test_table [n_tests_c] = '{
        '{32'h0000_1234, {5'd1, 5'd2, 5'd3, 5'd4}, 4'b0000, 1'b0},
        '{32'h0000_beef, {5'd2, 5'd1, 5'd1, 5'd3}, 4'b0010, 1'b0},
        '{32'hdead_a5c3, {5'd3, 5'd3, 5'd3, 5'd3}, 4'b1111, 1'b0},
        '{32'h0000_0f0f, {5'd4, 5'd2, 5'd5, 5'd3}, 4'b0100, 1'b1},
        '{32'hffff_8001, {5'd12, 5'd10, 5'd1, 5'd9}, 4'b1001, 1'b1},
        '{32'h0000_00ff, {5'd1, 5'd1, 5'd1, 5'd1}, 4'b0000, 1'b1}
    };

    // name column of the table in the same row order
    string test_names [n_tests_c] = '{
        "basic", "user_one", "user_all", "bp_rand", "bp_long", "single"
    };

    logic                                 clk = 1'b0;
    logic                                 rst;
    join_pkg::axis_beat_t [s_count_c-1:0] s_beat;
    logic [s_count_c-1:0]                 s_valid;
    logic [s_count_c-1:0]                 s_ready;
    join_pkg::axis_beat_t                 m_beat;
    logic                                 m_valid;
    logic                                 m_ready = 1'b0;
    join_pkg::wb_req_t                    wb_req;
    join_pkg::wb_rsp_t                    wb_rsp;
    logic                                 busy;

    join_pkg::axis_beat_t exp_q [$];
    join_pkg::axis_beat_t rx_q [$];
    logic   rand_mode = 1'b0;
    integer seed = 36473;
    integer rnd;
    int     busy_cycles = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycles = 0;
    int     cycle_limit;

    frame_join_top #(
        .S_COUNT    (s_count_c),
        .TAG_WIDTH  (tag_width_c),
        .FIFO_DEPTH (fifo_depth_c)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .busy    (busy)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // output sink and busy watch on the falling edge
    always @(negedge clk) begin
        // one draw per cycle keeps the random sequence fixed
        rnd = $random(seed);
        if (rand_mode) begin
            m_ready = rnd[0];
        end else begin
            m_ready = 1'b1;
        end
        if (busy) begin
            busy_cycles = busy_cycles + 1;
        end
        // a beat seen here moves on the next rising edge
        if (m_valid && m_ready) begin
            rx_q.push_back(m_beat);
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // output beats one row should give
    function automatic int row_beats(test_row_t row);
        int n;
        n = tag_words_c;
        for (int p = 0; p < s_count_c; p++) begin
            n = n + int'(row.len[p]);
        end
        return n;
    endfunction

    // tag words low first and then the frames in port order
    function automatic void build_expected(test_row_t row);
        join_pkg::axis_beat_t   b;
        logic [tag_width_c-1:0] tag_val;
        exp_q.delete();
        tag_val = row.tag[tag_width_c-1:0];
        for (int w = 0; w < tag_words_c; w++) begin
            b = '0;
            b.data = dw_c'(tag_val >> (dw_c * w));
            exp_q.push_back(b);
        end
        for (int p = 0; p < s_count_c; p++) begin
            for (int k = 0; k < int'(row.len[p]); k++) begin
                b = '0;
                b.data = dw_c'(p * 16 + k);
                // only the very last beat carries last and merged user
                if (p == s_count_c - 1 && k == int'(row.len[p]) - 1) begin
                    b.last = 1'b1;
                    b.user = |row.user;
                end
                exp_q.push_back(b);
            end
        end
    endfunction

    task automatic push_frame(int p, int len, logic user);
        for (int k = 0; k < len; k++) begin
            s_beat[p].data = dw_c'(p * 16 + k);
            s_beat[p].last = (k == len - 1);
            s_beat[p].user = user;
            s_valid[p] = 1'b1;
            // s_ready is registered and holds until the next rising edge
            while (!s_ready[p]) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        s_valid[p] = 1'b0;
    endtask

    // one classic cycle with read data taken on ack
    task automatic wb_cycle(logic we, logic [3:0] adr, logic [31:0] dat,
                            output logic [31:0] rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge clk);
        while (!wb_rsp.ack) begin
            @(negedge clk);
        end
        rdat = wb_rsp.dat;
        wb_req = '0;
        @(negedge clk);
        if (wb_rsp.ack) begin
            other_errors++;
            $display("wishbone ack stayed high for more than one cycle");
        end
    endtask

    task automatic check_beat(string name, int idx, join_pkg::axis_beat_t exp,
                              join_pkg::axis_beat_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s beat %0d expected data/last/user %h/%b/%b actual %h/%b/%b",
                     name, idx, exp.data, exp.last, exp.user, act.data, act.last, act.user);
        end
    endtask

    task automatic check_wb(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s wishbone read expected %h actual %h", name, exp, act);
        end
    endtask

    initial begin
        test_row_t   row;
        string       name;
        logic [31:0] rdat;
        int          rx_base;
        int          n_exp;
        int          busy_base;

        rst = 1'b1;
        s_beat = '0;
        s_valid = '0;
        wb_req = '0;
        cycle_limit = 200;
        for (int i = 0; i < n_tests_c; i++) begin
            cycle_limit = cycle_limit + 8 * row_beats(test_table[i]);
        end

        repeat (10) @(negedge clk);
        if (m_valid || s_ready != '0 || wb_rsp.ack || busy) begin
            other_errors++;
            $display("outputs were not all low at the end of reset");
        end
        rst = 1'b0;
        wb_cycle(1'b0, join_pkg::reg_tag_adr, 32'h0, rdat);
        check_wb("reset_tag", 32'h0, rdat);
        wb_cycle(1'b0, join_pkg::reg_count_adr, 32'h0, rdat);
        check_wb("reset_count", 32'h0, rdat);

        for (int i = 0; i < n_tests_c; i++) begin
            row = test_table[i];
            name = test_names[i];
            rand_mode = row.rand_ready;

            // new tag reads back masked to the tag width
            wb_cycle(1'b1, join_pkg::reg_tag_adr, row.tag, rdat);
            wb_cycle(1'b0, join_pkg::reg_tag_adr, 32'h0, rdat);
            check_wb(name, 32'(row.tag[tag_width_c-1:0]), rdat);

            build_expected(row);
            n_exp = exp_q.size();
            rx_base = rx_q.size();
            busy_base = busy_cycles;
            for (int p = 0; p < s_count_c; p++) begin
                push_frame(p, int'(row.len[p]), row.user[p]);
            end
            while (rx_q.size() < rx_base + n_exp) begin
                @(negedge clk);
            end
            // let the final beat leave the output register
            repeat (2) @(negedge clk);

            for (int k = 0; k < n_exp; k++) begin
                check_beat(name, k, exp_q[k], rx_q[rx_base + k]);
            end
            if (!rx_q[rx_base + n_exp - 1].last) begin
                other_errors++;
                $display("%s: the final output beat came without last", name);
            end
            if (rx_q.size() > rx_base + n_exp || m_valid) begin
                other_errors++;
                $display("%s: unexpected beat after the end of the joined frame", name);
            end
            if (busy) begin
                other_errors++;
                $display("%s: busy still high after the frame drained", name);
            end
            if (busy_cycles == busy_base) begin
                other_errors++;
                $display("%s: busy never went high during the frame", name);
            end
            wb_cycle(1'b0, join_pkg::reg_count_adr, 32'h0, rdat);
            check_wb(name, 32'(i + 1), rdat);
        end

        // any write to the counter clears it
        wb_cycle(1'b1, join_pkg::reg_count_adr, 32'h0, rdat);
        wb_cycle(1'b0, join_pkg::reg_count_adr, 32'h0, rdat);
        check_wb("count_clear", 32'h0, rdat);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/axis_input_fifo.sv ====
/*
 * Synchronous beat FIFO with valid/ready on both sides.
 * FIFO_DEPTH must be a power of two and at least 2.
 * in_ready is registered, so it is low for one cycle after reset
 * and drops the cycle after the last free slot is taken.
 */
module axis_input_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  join_pkg::axis_beat_t  in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output join_pkg::axis_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // beat storage
    join_pkg::axis_beat_t mem [FIFO_DEPTH];

    // pointers carry one extra wrap bit
    logic [AW:0] wr_ptr_reg;
    logic [AW:0] rd_ptr_reg;
    logic [AW:0] wr_ptr_next;
    logic [AW:0] rd_ptr_next;
    logic        in_ready_reg;
    logic        push;
    logic        pop;
    logic        empty;
    logic        full_next;

    assign empty = (wr_ptr_reg == rd_ptr_reg);
    assign push = in_valid && in_ready_reg;
    assign pop = out_valid && out_ready;

    assign wr_ptr_next = wr_ptr_reg + (AW+1)'(push);
    assign rd_ptr_next = rd_ptr_reg + (AW+1)'(pop);

    // full when the indices match but the wrap bits differ
    assign full_next = (wr_ptr_next[AW] != rd_ptr_next[AW]) &&
                       (wr_ptr_next[AW-1:0] == rd_ptr_next[AW-1:0]);

    assign in_ready = in_ready_reg;
    assign out_valid = !empty;
    assign out_beat = mem[rd_ptr_reg[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_reg <= '0;
            rd_ptr_reg <= '0;
            in_ready_reg <= 1'b0;
        end else begin
            wr_ptr_reg <= wr_ptr_next;
            rd_ptr_reg <= rd_ptr_next;
            // stall the source one cycle ahead of a full buffer
            in_ready_reg <= !full_next;
        end
    end

    // storage write, no reset on payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_reg[AW-1:0]] <= in_beat;
        end
    end

endmodule

// ==== hdl/axis_skid_out.sv ====
/*
 * Registered output stage with a two-entry skid.
 * int_ready_early is meant to be registered by the source, which then
 * offers int_valid only while that registered ready is high.
 * The temp register catches the one beat in flight when m_ready drops.
 */
module axis_skid_out (
    input  logic                  clk,
    input  logic                  rst,
    input  join_pkg::axis_beat_t  int_beat,
    input  logic                  int_valid,
    output logic                  int_ready_early,
    output join_pkg::axis_beat_t  m_beat,
    output logic                  m_valid,
    input  logic                  m_ready
);

    join_pkg::axis_beat_t m_beat_reg;
    join_pkg::axis_beat_t temp_beat_reg;
    logic                 m_valid_reg;
    logic                 temp_valid_reg;
    logic                 m_valid_next;
    logic                 temp_valid_next;

    // datapath steering
    logic                 int_to_out;
    logic                 int_to_temp;
    logic                 temp_to_out;

    assign m_beat = m_beat_reg;
    assign m_valid = m_valid_reg;

    // accept next cycle unless a beat would have to go into a full temp
    assign int_ready_early = m_ready ||
                             (!temp_valid_reg && (!m_valid_reg || !int_valid));

    always_comb begin
        m_valid_next = m_valid_reg;
        temp_valid_next = temp_valid_reg;
        int_to_out = 1'b0;
        int_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (int_valid) begin
            if (m_ready || !m_valid_reg) begin
                // output free or draining, go straight to output
                m_valid_next = 1'b1;
                int_to_out = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next = 1'b1;
                int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // no new beat, refill output from temp
            m_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            m_valid_reg <= m_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_beat_reg <= int_beat;
        end else if (temp_to_out) begin
            m_beat_reg <= temp_beat_reg;
        end
        if (int_to_temp) begin
            temp_beat_reg <= int_beat;
        end
    end

endmodule

// ==== hdl/frame_join_ctrl.sv ====
/*
 * Join control: sends the tag, then one frame from each port in order.
 * The tag is sampled on leaving idle and sent least significant word first.
 * Output last is set only on the final beat of port S_COUNT-1.
 * A port that never sends a frame stalls the block; there is no timeout.
 * TAG_WIDTH is limited to 32.
 */
module frame_join_ctrl #(
    parameter int S_COUNT = 4,
    parameter int TAG_WIDTH = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  join_pkg::axis_beat_t [S_COUNT-1:0]  fifo_beat,
    input  logic [S_COUNT-1:0]                   fifo_valid,
    output logic [S_COUNT-1:0]                   fifo_ready,
    input  logic [TAG_WIDTH-1:0]                 tag,
    output join_pkg::axis_beat_t                 int_beat,
    output logic                                 int_valid,
    input  logic                                 int_ready_early,
    output logic                                 frame_done,
    output logic                                 busy
);

    localparam int DW = join_pkg::data_width_c;
    localparam int TAG_WORDS = (TAG_WIDTH + DW - 1) / DW;
    localparam int TAG_SHIFT_W = TAG_WORDS * DW;
    localparam int PTR_W = (TAG_WORDS > 1) ? $clog2(TAG_WORDS) : 1;
    localparam int SEL_W = (S_COUNT > 1) ? $clog2(S_COUNT) : 1;

    typedef enum logic [1:0] {
        idle_s,
        write_tag_s,
        transfer_s
    } state_t;

    state_t state_reg;
    state_t state_next;

    logic [PTR_W-1:0]       tag_ptr_reg;
    logic [PTR_W-1:0]       tag_ptr_next;
    logic [SEL_W-1:0]       port_sel_reg;
    logic [SEL_W-1:0]       port_sel_next;
    logic                   user_reg;
    logic                   user_next;
    logic                   busy_reg;
    logic [TAG_SHIFT_W-1:0] tag_shift_reg;

    // early ready from the skid stage, registered
    logic                   int_ready_reg;

    // currently selected input
    join_pkg::axis_beat_t   sel_beat;
    logic                   sel_valid;

    assign sel_beat = fifo_beat[port_sel_reg];
    assign sel_valid = fifo_valid[port_sel_reg];

    // only the selected port, only while the skid stage accepts
    assign fifo_ready = (state_reg == transfer_s && int_ready_reg) ?
                        (S_COUNT'(1) << port_sel_reg) : '0;

    assign busy = busy_reg;

    always_comb begin
        state_next = state_reg;
        tag_ptr_next = tag_ptr_reg;
        port_sel_next = port_sel_reg;
        user_next = user_reg;
        int_beat = '0;
        int_valid = 1'b0;
        frame_done = 1'b0;

        case (state_reg)
            idle_s: begin
                tag_ptr_next = '0;
                port_sel_next = '0;
                user_next = 1'b0;
                // a frame waiting on port 0 starts the join
                if (fifo_valid[0]) begin
                    state_next = write_tag_s;
                end
            end
            write_tag_s: begin
                if (int_ready_reg) begin
                    int_valid = 1'b1;
                    int_beat.data = tag_shift_reg[DW-1:0];
                    if (tag_ptr_reg == PTR_W'(TAG_WORDS - 1)) begin
                        state_next = transfer_s;
                    end else begin
                        tag_ptr_next = tag_ptr_reg + 1'b1;
                    end
                end
            end
            transfer_s: begin
                if (sel_valid && int_ready_reg) begin
                    int_valid = 1'b1;
                    int_beat.data = sel_beat.data;
                    if (sel_beat.last) begin
                        // end of this port's frame, move on
                        port_sel_next = port_sel_reg + 1'b1;
                        user_next = user_reg | sel_beat.user;
                        if (port_sel_reg == SEL_W'(S_COUNT - 1)) begin
                            // final port closes the joined frame
                            int_beat.last = 1'b1;
                            int_beat.user = user_next;
                            frame_done = 1'b1;
                            state_next = idle_s;
                        end
                    end
                end
            end
            default: begin
                state_next = idle_s;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= idle_s;
            tag_ptr_reg <= '0;
            port_sel_reg <= '0;
            user_reg <= 1'b0;
            busy_reg <= 1'b0;
            int_ready_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            tag_ptr_reg <= tag_ptr_next;
            port_sel_reg <= port_sel_next;
            user_reg <= user_next;
            busy_reg <= (state_next != idle_s);
            int_ready_reg <= int_ready_early;
        end
    end

    // tag shift register, loaded on leaving idle
    always_ff @(posedge clk) begin
        if (state_reg == idle_s && fifo_valid[0]) begin
            tag_shift_reg <= TAG_SHIFT_W'(tag);
        end else if (state_reg == write_tag_s && int_valid) begin
            tag_shift_reg <= tag_shift_reg >> DW;
        end
    end

endmodule

// ==== hdl/frame_join_top.sv ====
/*
 * Frame join subsystem top level.
 * Joins one frame from each of S_COUNT inputs behind a tag from the register
 * block. Ports are served in fixed order 0 to S_COUNT-1.
 * TAG_WIDTH up to 32; FIFO_DEPTH a power of two, at least 2.
 */
module frame_join_top #(
    parameter int S_COUNT = 4,
    parameter int TAG_WIDTH = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  join_pkg::axis_beat_t [S_COUNT-1:0]  s_beat,
    input  logic [S_COUNT-1:0]                   s_valid,
    output logic [S_COUNT-1:0]                   s_ready,
    output join_pkg::axis_beat_t                 m_beat,
    output logic                                 m_valid,
    input  logic                                 m_ready,
    input  join_pkg::wb_req_t                    wb_req,
    output join_pkg::wb_rsp_t                    wb_rsp,
    output logic                                 busy
);

    join_pkg::axis_beat_t [S_COUNT-1:0] fifo_beat;
    logic [S_COUNT-1:0]                 fifo_valid;
    logic [S_COUNT-1:0]                 fifo_ready;
    join_pkg::axis_beat_t               int_beat;
    logic                               int_valid;
    logic                               int_ready_early;
    logic [TAG_WIDTH-1:0]               tag;
    logic                               frame_done;

    // one buffer per input so later ports can fill ahead
    for (genvar i = 0; i < S_COUNT; i++) begin : g_fifo
        axis_input_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (s_beat[i]),
            .in_valid  (s_valid[i]),
            .in_ready  (s_ready[i]),
            .out_beat  (fifo_beat[i]),
            .out_valid (fifo_valid[i]),
            .out_ready (fifo_ready[i])
        );
    end

    frame_join_ctrl #(
        .S_COUNT   (S_COUNT),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .fifo_beat       (fifo_beat),
        .fifo_valid      (fifo_valid),
        .fifo_ready      (fifo_ready),
        .tag             (tag),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .int_ready_early (int_ready_early),
        .frame_done      (frame_done),
        .busy            (busy)
    );

    // registered output with back-pressure absorption
    axis_skid_out u_skid (
        .clk             (clk),
        .rst             (rst),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .int_ready_early (int_ready_early),
        .m_beat          (m_beat),
        .m_valid         (m_valid),
        .m_ready         (m_ready)
    );

    join_wb_regs #(
        .TAG_WIDTH (TAG_WIDTH)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .frame_done (frame_done),
        .tag        (tag)
    );

endmodule

// ==== hdl/join_pkg.sv ====
/*
 * Shared types and constants for the frame join subsystem.
 * The stream data width is fixed here and is not a module parameter.
 * The Wishbone port is classic cycles only, 32-bit data and word addresses.
 * Register addresses are word indices on the 4-bit adr field.
 */
package join_pkg;

    // stream data width in bits
    localparam int data_width_c = 8;

    // one stream beat, sideband next to the data
    typedef struct packed {
        logic [data_width_c-1:0] data;
        logic                    last;
        logic                    user;
    } axis_beat_t;

    // Wishbone classic request from the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response back to the master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // tag register, read/write, upper bits read as zero
    localparam logic [3:0] reg_tag_adr = 4'd0;

    // joined-frame counter, read-only, any write clears it
    localparam logic [3:0] reg_count_adr = 4'd1;

endpackage

// ==== hdl/join_wb_regs.sv ====
/*
 * Wishbone classic slave for tag and joined-frame counter.
 * ack follows a request by one cycle and stays high for one cycle.
 * Writes land on the edge that raises ack; read data comes with ack.
 * A write to the counter clears it and wins over a same-cycle increment.
 * Unmapped addresses read zero and ignore writes.
 */
module join_wb_regs #(
    parameter int TAG_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  join_pkg::wb_req_t    wb_req,
    output join_pkg::wb_rsp_t    wb_rsp,
    input  logic                 frame_done,
    output logic [TAG_WIDTH-1:0] tag
);

    logic                 ack_reg;
    logic [31:0]          rd_dat_reg;
    logic [TAG_WIDTH-1:0] tag_reg;
    logic [31:0]          count_reg;
    logic                 req;
    logic                 wr_tag;
    logic                 wr_count;
    logic [31:0]          rd_mux;

    // new request, ack low in between back-to-back cycles
    assign req = wb_req.cyc && wb_req.stb && !ack_reg;

    assign wr_tag = req && wb_req.we && (wb_req.adr == join_pkg::reg_tag_adr);
    assign wr_count = req && wb_req.we && (wb_req.adr == join_pkg::reg_count_adr);

    // read decode
    always_comb begin
        case (wb_req.adr)
            join_pkg::reg_tag_adr: rd_mux = 32'(tag_reg);
            join_pkg::reg_count_adr: rd_mux = count_reg;
            default: rd_mux = '0;
        endcase
    end

    assign wb_rsp.ack = ack_reg;
    assign wb_rsp.dat = rd_dat_reg;
    assign tag = tag_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_reg <= 1'b0;
            tag_reg <= '0;
            count_reg <= '0;
        end else begin
            ack_reg <= req;
            if (wr_tag) begin
                tag_reg <= wb_req.dat[TAG_WIDTH-1:0];
            end
            if (wr_count) begin
                count_reg <= '0;
            end else if (frame_done) begin
                count_reg <= count_reg + 32'd1;
            end
        end
    end

    // read data register, only meaningful with ack
    always_ff @(posedge clk) begin
        if (req && !wb_req.we) begin
            rd_dat_reg <= rd_mux;
        end
    end

endmodule

// ==== verilog.f ====
hdl/join_pkg.sv
hdl/axis_input_fifo.sv
hdl/frame_join_ctrl.sv
hdl/axis_skid_out.sv
hdl/join_wb_regs.sv
hdl/frame_join_top.sv
bench/frame_join_tb.sv
